//--- src/lsu_macros.svh
/* load/store unit macros
   bus widths, SRAM window and the lane-aligned device region */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// bus widths
`define LSU_DATA_LEN 32
`define LSU_ADDR_LEN 32

// simulation SRAM window, depth in 32-bit words
`define LSU_SRAM_BASE 32'h8000_0000
`define LSU_SRAM_WORDS 256

// lane-aligned device region, covers the whole SRAM window
`define LSU_ALIGN_LO `LSU_SRAM_BASE
`define LSU_ALIGN_HI (`LSU_SRAM_BASE + 32'(`LSU_SRAM_WORDS) * 32'd4 - 32'd1)

`endif

//--- src/lsu_pkg.sv
/* load/store unit package
   request types, AXI-lite encodings and controller states */
`default_nettype none

package lsu_pkg;

	// load kinds, none marks a non-load
	typedef enum logic [2:0] {
		LOAD_NONE = 3'd0,
		LOAD_LB   = 3'd1,
		LOAD_LH   = 3'd2,
		LOAD_LW   = 3'd3,
		LOAD_LBU  = 3'd4,
		LOAD_LHU  = 3'd5
	} load_type_e;

	// store kinds, none marks a non-store
	typedef enum logic [1:0] {
		STORE_NONE = 2'd0,
		STORE_SB   = 2'd1,
		STORE_SH   = 2'd2,
		STORE_SW   = 2'd3
	} store_type_e;

	// AXI transfer size, log2 of the byte count
	typedef enum logic [2:0] {
		SIZE_1 = 3'b000,
		SIZE_2 = 3'b001,
		SIZE_4 = 3'b010
	} axi_size_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_e;

	// controller states
	typedef enum logic [1:0] {
		S_IDLE = 2'd0,
		S_ADDR = 2'd1,
		S_RESP = 2'd2,
		S_DONE = 2'd3
	} lsu_state_e;

endpackage

`default_nettype wire

//--- src/lsu_store_align.sv
/* store aligner
   builds the byte strobe and lane-shifted write data for a store */
`default_nettype none
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_store_align (
	input  wire [`LSU_ADDR_LEN-1:0]      alu_result_i,
	input  wire [`LSU_DATA_LEN-1:0]      store_data_i,
	input  wire lsu_pkg::store_type_e    store_type_i,
	output logic [`LSU_DATA_LEN-1:0]     w_data_o,
	output logic [`LSU_DATA_LEN/8-1:0]   w_strb_o
);

	logic [`LSU_DATA_LEN/8-1:0] strb;
	logic [1:0] offset;
	logic in_align;

	assign offset = alu_result_i[1:0];
	assign in_align = (alu_result_i >= `LSU_ALIGN_LO) && (alu_result_i <= `LSU_ALIGN_HI);

	// low-lane strobe by store width
	always_comb begin
		case (store_type_i)
			lsu_pkg::STORE_SB: strb = 4'b0001;
			lsu_pkg::STORE_SH: strb = 4'b0011;
			lsu_pkg::STORE_SW: strb = 4'b1111;
			default: strb = 4'b0000;
		endcase
	end

	// device region gets lane placement, everything else goes out as is
	assign w_data_o = in_align ? (store_data_i << {offset, 3'b000}) : store_data_i;
	assign w_strb_o = in_align ? (strb << offset) : strb;

endmodule

`default_nettype wire

//--- src/lsu_load_extend.sv
/* load extender
   shifts raw read data down to lane 0 and sign- or zero-extends it */
`default_nettype none
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_load_extend (
	input  wire [`LSU_DATA_LEN-1:0]   raw_rdata_i,
	input  wire [1:0]                 ld_offset_i,
	input  wire                       ld_aligned_i,
	input  wire lsu_pkg::load_type_e  load_type_i,
	output logic [`LSU_DATA_LEN-1:0]  ld_result_o
);

	logic [`LSU_DATA_LEN-1:0] shifted;

	// only the device region has lane-placed data
	assign shifted = ld_aligned_i ? (raw_rdata_i >> {ld_offset_i, 3'b000}) : raw_rdata_i;

	always_comb begin
		case (load_type_i)
			lsu_pkg::LOAD_LB: begin
				ld_result_o = {{(`LSU_DATA_LEN-8){shifted[7]}}, shifted[7:0]};
			end
			lsu_pkg::LOAD_LH: begin
				ld_result_o = {{(`LSU_DATA_LEN-16){shifted[15]}}, shifted[15:0]};
			end
			lsu_pkg::LOAD_LBU: begin
				ld_result_o = {{(`LSU_DATA_LEN-8){1'b0}}, shifted[7:0]};
			end
			lsu_pkg::LOAD_LHU: begin
				ld_result_o = {{(`LSU_DATA_LEN-16){1'b0}}, shifted[15:0]};
			end
			// lw and anything else return the whole word
			default: begin
				ld_result_o = shifted;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/lsu_ctrl.sv
/* load/store controller
   request FSM driving the AXI-lite channels and capturing responses */
`default_nettype none
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_ctrl (
	input  wire                          clock,
	input  wire                          rstn,
	input  wire                          req_valid_i,
	input  wire [`LSU_ADDR_LEN-1:0]      alu_result_i,
	input  wire lsu_pkg::load_type_e     load_type_i,
	input  wire lsu_pkg::store_type_e    store_type_i,
	input  wire [`LSU_DATA_LEN-1:0]      w_data_al_i,
	input  wire [`LSU_DATA_LEN/8-1:0]    w_strb_al_i,
	input  wire [`LSU_DATA_LEN-1:0]      ld_result_i,
	// read address
	output logic [`LSU_ADDR_LEN-1:0]     ar_addr_o,
	output lsu_pkg::axi_size_e           ar_size_o,
	output logic                         ar_valid_o,
	input  wire                          ar_ready_i,
	// read data
	input  wire [`LSU_DATA_LEN-1:0]      r_data_i,
	input  wire lsu_pkg::axi_resp_e      r_resp_i,
	input  wire                          r_valid_i,
	output logic                         r_ready_o,
	// write address
	output logic [`LSU_ADDR_LEN-1:0]     aw_addr_o,
	output lsu_pkg::axi_size_e           aw_size_o,
	output logic                         aw_valid_o,
	input  wire                          aw_ready_i,
	// write data
	output logic [`LSU_DATA_LEN-1:0]     w_data_o,
	output logic [`LSU_DATA_LEN/8-1:0]   w_strb_o,
	output logic                         w_valid_o,
	input  wire                          w_ready_i,
	// write response
	input  wire lsu_pkg::axi_resp_e      b_resp_i,
	input  wire                          b_valid_i,
	output logic                         b_ready_o,
	// to the load extender
	output logic [`LSU_DATA_LEN-1:0]     raw_rdata_o,
	output logic [1:0]                   ld_offset_o,
	output logic                         ld_aligned_o,
	// completion
	output logic                         done_o,
	output logic [`LSU_DATA_LEN-1:0]     wdata_o,
	output logic                         err_o,
	output logic                         mem_inst_o
);

	lsu_pkg::lsu_state_e state_q;
	lsu_pkg::lsu_state_e state_d;
	logic is_load;
	logic is_store;
	logic aw_done_q;
	logic w_done_q;
	logic aw_ok;
	logic w_ok;
	logic r_hs;
	logic b_hs;
	logic err_q;
	logic in_align;

	assign is_load = (load_type_i != lsu_pkg::LOAD_NONE);
	assign is_store = (store_type_i != lsu_pkg::STORE_NONE);
	assign in_align = (alu_result_i >= `LSU_ALIGN_LO) && (alu_result_i <= `LSU_ALIGN_HI);

	// address phase, loads take priority over stores
	assign ar_valid_o = (state_q == lsu_pkg::S_ADDR) && is_load;
	assign aw_valid_o = (state_q == lsu_pkg::S_ADDR) && !is_load && is_store && !aw_done_q;
	assign w_valid_o = (state_q == lsu_pkg::S_ADDR) && !is_load && is_store && !w_done_q;
	assign ar_addr_o = alu_result_i;
	assign aw_addr_o = alu_result_i;
	assign w_data_o = w_data_al_i;
	assign w_strb_o = w_strb_al_i;

	// write address and data may handshake in different cycles
	assign aw_ok = aw_done_q || (aw_valid_o && aw_ready_i);
	assign w_ok = w_done_q || (w_valid_o && w_ready_i);

	// response phase
	assign r_ready_o = (state_q == lsu_pkg::S_RESP) && is_load;
	assign b_ready_o = (state_q == lsu_pkg::S_RESP) && !is_load && is_store;
	assign r_hs = r_valid_i && r_ready_o;
	assign b_hs = b_valid_i && b_ready_o;

	always_comb begin
		case (load_type_i)
			lsu_pkg::LOAD_LB, lsu_pkg::LOAD_LBU: ar_size_o = lsu_pkg::SIZE_1;
			lsu_pkg::LOAD_LH, lsu_pkg::LOAD_LHU: ar_size_o = lsu_pkg::SIZE_2;
			default: ar_size_o = lsu_pkg::SIZE_4;
		endcase
	end

	always_comb begin
		case (store_type_i)
			lsu_pkg::STORE_SB: aw_size_o = lsu_pkg::SIZE_1;
			lsu_pkg::STORE_SH: aw_size_o = lsu_pkg::SIZE_2;
			default: aw_size_o = lsu_pkg::SIZE_4;
		endcase
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			lsu_pkg::S_IDLE: begin
				if (req_valid_i)
					state_d = lsu_pkg::S_ADDR;
			end
			lsu_pkg::S_ADDR: begin
				// non-memory requests skip the bus entirely
				if (!is_load && !is_store)
					state_d = lsu_pkg::S_DONE;
				else if (is_load && ar_ready_i)
					state_d = lsu_pkg::S_RESP;
				else if (!is_load && aw_ok && w_ok)
					state_d = lsu_pkg::S_RESP;
			end
			lsu_pkg::S_RESP: begin
				if (r_hs || b_hs)
					state_d = lsu_pkg::S_DONE;
			end
			default: begin
				state_d = lsu_pkg::S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q <= lsu_pkg::S_IDLE;
			aw_done_q <= 1'b0;
			w_done_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// handshake flags only live inside the address phase
			if (state_d == lsu_pkg::S_ADDR && state_q == lsu_pkg::S_ADDR) begin
				aw_done_q <= aw_ok;
				w_done_q <= w_ok;
			end else begin
				aw_done_q <= 1'b0;
				w_done_q <= 1'b0;
			end
			if (state_q == lsu_pkg::S_IDLE && req_valid_i)
				err_q <= 1'b0;
			else if (r_hs)
				err_q <= (r_resp_i != lsu_pkg::RESP_OKAY);
			else if (b_hs)
				err_q <= (b_resp_i != lsu_pkg::RESP_OKAY);
		end
	end

	// read payload, an error reads back as zero
	always_ff @(posedge clock) begin
		if (r_hs) begin
			raw_rdata_o <= (r_resp_i == lsu_pkg::RESP_OKAY) ? r_data_i : '0;
			ld_offset_o <= alu_result_i[1:0];
			ld_aligned_o <= in_align;
		end
	end

	assign done_o = (state_q == lsu_pkg::S_DONE);
	assign err_o = err_q;
	assign wdata_o = is_load ? ld_result_i : alu_result_i;
	assign mem_inst_o = (state_q != lsu_pkg::S_IDLE) && (is_load || is_store);

endmodule

`default_nettype wire

//--- src/axi_sram.sv
/* behavioural AXI-lite SRAM slave
   byte-strobed writes, fixed read latency, slverr outside the window */
`default_nettype none
`timescale 1ns/1ns
`include "lsu_macros.svh"

module axi_sram #(
	parameter int READ_LATENCY = 2
) (
	input  wire                          clock,
	input  wire                          rstn,
	input  wire [`LSU_ADDR_LEN-1:0]      ar_addr_i,
	input  wire lsu_pkg::axi_size_e      ar_size_i,
	input  wire                          ar_valid_i,
	output logic                         ar_ready_o,
	output logic [`LSU_DATA_LEN-1:0]     r_data_o,
	output lsu_pkg::axi_resp_e           r_resp_o,
	output logic                         r_valid_o,
	input  wire                          r_ready_i,
	input  wire [`LSU_ADDR_LEN-1:0]      aw_addr_i,
	input  wire lsu_pkg::axi_size_e      aw_size_i,
	input  wire                          aw_valid_i,
	output logic                         aw_ready_o,
	input  wire [`LSU_DATA_LEN-1:0]      w_data_i,
	input  wire [`LSU_DATA_LEN/8-1:0]    w_strb_i,
	input  wire                          w_valid_i,
	output logic                         w_ready_o,
	output lsu_pkg::axi_resp_e           b_resp_o,
	output logic                         b_valid_o,
	input  wire                          b_ready_i
);

	localparam int IDX_W = $clog2(`LSU_SRAM_WORDS);
	localparam int CNT_W = $clog2(READ_LATENCY + 1);
	localparam int LANES = `LSU_DATA_LEN / 8;

	logic [`LSU_DATA_LEN-1:0] mem [`LSU_SRAM_WORDS];
	logic [`LSU_ADDR_LEN-1:0] rd_addr_q;
	lsu_pkg::axi_size_e rd_size_q;
	logic [CNT_W-1:0] rd_cnt_q;
	logic rd_busy_q;
	logic [LANES-1:0] rd_mask;
	logic [LANES-1:0] wr_mask;
	logic wr_accept;

	function automatic logic in_window(input logic [`LSU_ADDR_LEN-1:0] addr);
		logic [`LSU_ADDR_LEN-1:0] off;
		off = addr - `LSU_SRAM_BASE;
		return (addr >= `LSU_SRAM_BASE) && (off[`LSU_ADDR_LEN-1:2] < `LSU_SRAM_WORDS);
	endfunction

	function automatic logic [IDX_W-1:0] word_idx(input logic [`LSU_ADDR_LEN-1:0] addr);
		logic [`LSU_ADDR_LEN-1:0] off;
		off = addr - `LSU_SRAM_BASE;
		return off[IDX_W+1:2];
	endfunction

	// lanes touched by a transfer of the given size at this byte offset
	function automatic logic [LANES-1:0] lane_mask(input logic [1:0] off,
			input lsu_pkg::axi_size_e size);
		logic [LANES-1:0] base;
		case (size)
			lsu_pkg::SIZE_1: base = 4'b0001;
			lsu_pkg::SIZE_2: base = 4'b0011;
			default: base = 4'b1111;
		endcase
		return base << off;
	endfunction

	initial begin
		for (int i = 0; i < `LSU_SRAM_WORDS; i++)
			mem[i] = '0;
	end

	assign ar_ready_o = !rd_busy_q && !r_valid_o;
	assign rd_mask = lane_mask(rd_addr_q[1:0], rd_size_q);

	// read side, counts down the latency then holds data until taken
	always_ff @(posedge clock) begin
		if (!rstn) begin
			rd_busy_q <= 1'b0;
			r_valid_o <= 1'b0;
		end else if (ar_valid_i && ar_ready_o) begin
			rd_busy_q <= 1'b1;
		end else if (rd_busy_q && rd_cnt_q == '0) begin
			rd_busy_q <= 1'b0;
			r_valid_o <= 1'b1;
		end else if (r_valid_o && r_ready_i) begin
			r_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_valid_i && ar_ready_o) begin
			rd_addr_q <= ar_addr_i;
			rd_size_q <= ar_size_i;
			rd_cnt_q <= CNT_W'(READ_LATENCY - 1);
		end else if (rd_busy_q && rd_cnt_q != '0) begin
			rd_cnt_q <= rd_cnt_q - 1'b1;
		end
		if (rd_busy_q && rd_cnt_q == '0) begin
			for (int i = 0; i < LANES; i++)
				r_data_o[8*i +: 8] <= (in_window(rd_addr_q) && rd_mask[i]) ?
					mem[word_idx(rd_addr_q)][8*i +: 8] : 8'h00;
			r_resp_o <= in_window(rd_addr_q) ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
		end
	end

	// write side takes address and data together
	assign wr_accept = aw_valid_i && w_valid_i && !b_valid_o;
	assign aw_ready_o = wr_accept;
	assign w_ready_o = wr_accept;
	assign wr_mask = w_strb_i & lane_mask(aw_addr_i[1:0], aw_size_i);

	always_ff @(posedge clock) begin
		if (!rstn)
			b_valid_o <= 1'b0;
		else if (wr_accept)
			b_valid_o <= 1'b1;
		else if (b_ready_i)
			b_valid_o <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (wr_accept) begin
			b_resp_o <= in_window(aw_addr_i) ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
			if (in_window(aw_addr_i)) begin
				for (int i = 0; i < LANES; i++)
					if (wr_mask[i])
						mem[word_idx(aw_addr_i)][8*i +: 8] <= w_data_i[8*i +: 8];
			end
		end
	end

endmodule

`default_nettype wire

//--- src/lsu_subsys_top.sv
/* load/store subsystem top
   controller, aligners and the AXI SRAM slave */
`default_nettype none
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_subsys_top (
	input  wire                          clock,
	input  wire                          rstn,
	input  wire                          req_valid_i,
	input  wire [`LSU_ADDR_LEN-1:0]      alu_result_i,
	input  wire [`LSU_DATA_LEN-1:0]      store_data_i,
	input  wire lsu_pkg::load_type_e     load_type_i,
	input  wire lsu_pkg::store_type_e    store_type_i,
	output wire                          done_o,
	output wire [`LSU_DATA_LEN-1:0]      wdata_o,
	output wire                          err_o,
	output wire                          mem_inst_o
);

	wire [`LSU_DATA_LEN-1:0] w_data_al;
	wire [`LSU_DATA_LEN/8-1:0] w_strb_al;
	wire [`LSU_DATA_LEN-1:0] ld_result;
	wire [`LSU_DATA_LEN-1:0] raw_rdata;
	wire [1:0] ld_offset;
	wire ld_aligned;

	// AXI-lite between controller and memory
	wire [`LSU_ADDR_LEN-1:0] ar_addr;
	lsu_pkg::axi_size_e ar_size;
	wire ar_valid;
	wire ar_ready;
	wire [`LSU_DATA_LEN-1:0] r_data;
	lsu_pkg::axi_resp_e r_resp;
	wire r_valid;
	wire r_ready;
	wire [`LSU_ADDR_LEN-1:0] aw_addr;
	lsu_pkg::axi_size_e aw_size;
	wire aw_valid;
	wire aw_ready;
	wire [`LSU_DATA_LEN-1:0] w_data;
	wire [`LSU_DATA_LEN/8-1:0] w_strb;
	wire w_valid;
	wire w_ready;
	lsu_pkg::axi_resp_e b_resp;
	wire b_valid;
	wire b_ready;

	lsu_store_align u_store_align (
		.alu_result_i (alu_result_i),
		.store_data_i (store_data_i),
		.store_type_i (store_type_i),
		.w_data_o     (w_data_al),
		.w_strb_o     (w_strb_al)
	);

	lsu_load_extend u_load_extend (
		.raw_rdata_i  (raw_rdata),
		.ld_offset_i  (ld_offset),
		.ld_aligned_i (ld_aligned),
		.load_type_i  (load_type_i),
		.ld_result_o  (ld_result)
	);

	lsu_ctrl u_ctrl (
		.clock        (clock),
		.rstn         (rstn),
		.req_valid_i  (req_valid_i),
		.alu_result_i (alu_result_i),
		.load_type_i  (load_type_i),
		.store_type_i (store_type_i),
		.w_data_al_i  (w_data_al),
		.w_strb_al_i  (w_strb_al),
		.ld_result_i  (ld_result),
		.ar_addr_o    (ar_addr),
		.ar_size_o    (ar_size),
		.ar_valid_o   (ar_valid),
		.ar_ready_i   (ar_ready),
		.r_data_i     (r_data),
		.r_resp_i     (r_resp),
		.r_valid_i    (r_valid),
		.r_ready_o    (r_ready),
		.aw_addr_o    (aw_addr),
		.aw_size_o    (aw_size),
		.aw_valid_o   (aw_valid),
		.aw_ready_i   (aw_ready),
		.w_data_o     (w_data),
		.w_strb_o     (w_strb),
		.w_valid_o    (w_valid),
		.w_ready_i    (w_ready),
		.b_resp_i     (b_resp),
		.b_valid_i    (b_valid),
		.b_ready_o    (b_ready),
		.raw_rdata_o  (raw_rdata),
		.ld_offset_o  (ld_offset),
		.ld_aligned_o (ld_aligned),
		.done_o       (done_o),
		.wdata_o      (wdata_o),
		.err_o        (err_o),
		.mem_inst_o   (mem_inst_o)
	);

	axi_sram #(
		.READ_LATENCY (2)
	) u_sram (
		.clock      (clock),
		.rstn       (rstn),
		.ar_addr_i  (ar_addr),
		.ar_size_i  (ar_size),
		.ar_valid_i (ar_valid),
		.ar_ready_o (ar_ready),
		.r_data_o   (r_data),
		.r_resp_o   (r_resp),
		.r_valid_o  (r_valid),
		.r_ready_i  (r_ready),
		.aw_addr_i  (aw_addr),
		.aw_size_i  (aw_size),
		.aw_valid_i (aw_valid),
		.aw_ready_o (aw_ready),
		.w_data_i   (w_data),
		.w_strb_i   (w_strb),
		.w_valid_i  (w_valid),
		.w_ready_o  (w_ready),
		.b_resp_o   (b_resp),
		.b_valid_o  (b_valid),
		.b_ready_i  (b_ready)
	);

endmodule

`default_nettype wire

//--- verif/lsu_tb.sv
/* load/store subsystem testbench
   replays a request trace and checks results against a reference memory */
`default_nettype none
`timescale 1ns/1ns
`include "lsu_macros.svh"

module lsu_tb;

	localparam int MAX_REQS = 64;
	localparam int FIELDS = 6;
	localparam int TIDX_W = $clog2(MAX_REQS * FIELDS);
	localparam int WIDX_W = $clog2(`LSU_SRAM_WORDS);
	localparam logic [31:0] EMPTY = 32'hffff_ffff;
	// request kinds as written in the trace
	localparam logic [31:0] KIND_ALU = 32'd0;
	localparam logic [31:0] KIND_LOAD = 32'd1;
	localparam logic [31:0] KIND_STORE = 32'd2;

	logic clock;
	logic rstn;
	logic req_valid_i;
	logic [`LSU_ADDR_LEN-1:0] alu_result_i;
	logic [`LSU_DATA_LEN-1:0] store_data_i;
	lsu_pkg::load_type_e load_type_i;
	lsu_pkg::store_type_e store_type_i;
	wire done_o;
	wire [`LSU_DATA_LEN-1:0] wdata_o;
	wire err_o;
	wire mem_inst_o;

	logic [31:0] trace_mem [MAX_REQS*FIELDS];
	logic [`LSU_DATA_LEN-1:0] ref_mem [`LSU_SRAM_WORDS];
	lsu_pkg::lsu_state_e ctrl_state;
	int num_reqs;
	int req_index = 0;
	int cycle_count = 0;
	int cycle_limit = 100;

	lsu_subsys_top dut0 (
		.clock        (clock),
		.rstn         (rstn),
		.req_valid_i  (req_valid_i),
		.alu_result_i (alu_result_i),
		.store_data_i (store_data_i),
		.load_type_i  (load_type_i),
		.store_type_i (store_type_i),
		.done_o       (done_o),
		.wdata_o      (wdata_o),
		.err_o        (err_o),
		.mem_inst_o   (mem_inst_o)
	);

	assign ctrl_state = dut0.u_ctrl.state_q;

	always #5 clock = ~clock;

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	// guard against a hung handshake
	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout after %0d cycles at request %0d, controller in %s",
				cycle_count, req_index, ctrl_state.name());
			stop_run();
		end
	end

	task automatic check_data(input string name, input logic [`LSU_DATA_LEN-1:0] got,
			input logic [`LSU_DATA_LEN-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%h expected 0x%h (request %0d)", name, got, exp, req_index);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%h expected 0x%h (request %0d)", name, got, exp, req_index);
			stop_run();
		end
	endtask

	task automatic check_cycles(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h (request %0d)", name, got, exp,
				req_index);
			stop_run();
		end
	endtask

	function automatic logic [31:0] trace_field(input int n, input int k);
		return trace_mem[TIDX_W'(FIELDS * n + k)];
	endfunction

	function automatic logic addr_in_window(input logic [`LSU_ADDR_LEN-1:0] addr);
		return (addr >= `LSU_SRAM_BASE) && (addr < `LSU_SRAM_BASE + 32'(`LSU_SRAM_WORDS * 4));
	endfunction

	function automatic logic [WIDX_W-1:0] word_of(input logic [`LSU_ADDR_LEN-1:0] addr);
		logic [`LSU_ADDR_LEN-1:0] off;
		off = addr - `LSU_SRAM_BASE;
		return off[WIDX_W+1:2];
	endfunction

	// bytes go to lanes from the offset upwards, only inside the device region
	task automatic predict_store(input logic [`LSU_ADDR_LEN-1:0] addr,
			input logic [`LSU_DATA_LEN-1:0] data, input lsu_pkg::store_type_e st,
			output logic err);
		logic [`LSU_DATA_LEN-1:0] word;
		logic [1:0] first;
		logic [2:0] nbytes;
		logic [2:0] lane;
		err = !addr_in_window(addr);
		if (!err) begin
			nbytes = (st == lsu_pkg::STORE_SB) ? 3'd1 : (st == lsu_pkg::STORE_SH) ? 3'd2 : 3'd4;
			first = (addr >= `LSU_ALIGN_LO && addr <= `LSU_ALIGN_HI) ? addr[1:0] : 2'd0;
			word = ref_mem[word_of(addr)];
			for (logic [2:0] b = 3'd0; b < nbytes; b++) begin
				lane = {1'b0, first} + b;
				if (lane < 3'd4)
					word[{lane[1:0], 3'b000} +: 8] = data[{b[1:0], 3'b000} +: 8];
			end
			ref_mem[word_of(addr)] = word;
		end
	endtask

	task automatic predict_load(input logic [`LSU_ADDR_LEN-1:0] addr,
			input lsu_pkg::load_type_e lt, output logic [`LSU_DATA_LEN-1:0] result,
			output logic err);
		logic [2*`LSU_DATA_LEN-1:0] wide;
		logic [1:0] first;
		logic [7:0] byte_v;
		logic [15:0] half_v;
		err = !addr_in_window(addr);
		result = '0;
		if (!err) begin
			first = (addr >= `LSU_ALIGN_LO && addr <= `LSU_ALIGN_HI) ? addr[1:0] : 2'd0;
			wide = {{`LSU_DATA_LEN{1'b0}}, ref_mem[word_of(addr)]};
			byte_v = wide[{1'b0, first, 3'b000} +: 8];
			half_v = wide[{1'b0, first, 3'b000} +: 16];
			case (lt)
				lsu_pkg::LOAD_LB: result = {{(`LSU_DATA_LEN-8){byte_v[7]}}, byte_v};
				lsu_pkg::LOAD_LBU: result = {{(`LSU_DATA_LEN-8){1'b0}}, byte_v};
				lsu_pkg::LOAD_LH: result = {{(`LSU_DATA_LEN-16){half_v[15]}}, half_v};
				lsu_pkg::LOAD_LHU: result = {{(`LSU_DATA_LEN-16){1'b0}}, half_v};
				default: result = wide[`LSU_DATA_LEN-1:0];
			endcase
		end
	endtask

	task automatic issue_request(input logic [31:0] kind, input logic [31:0] typ,
			input logic [`LSU_ADDR_LEN-1:0] addr, input logic [`LSU_DATA_LEN-1:0] data);
		@(posedge clock);
		#1;
		alu_result_i = addr;
		store_data_i = data;
		load_type_i = (kind == KIND_LOAD) ? lsu_pkg::load_type_e'(typ[2:0]) : lsu_pkg::LOAD_NONE;
		store_type_i = (kind == KIND_STORE) ? lsu_pkg::store_type_e'(typ[1:0]) :
			lsu_pkg::STORE_NONE;
		req_valid_i = 1'b1;
	endtask

	// counts cycles from the start pulse, mem_inst_o checked in each one
	task automatic wait_for_done(input logic exp_mem, output int cycles);
		cycles = 0;
		do begin
			@(posedge clock);
			#1;
			req_valid_i = 1'b0;
			cycles++;
			@(negedge clock);
			check_flag("mem_inst_o", mem_inst_o, exp_mem);
		end while (!done_o);
	endtask

	initial begin
		logic [31:0] kind;
		logic [31:0] typ;
		logic [31:0] err_field;
		logic [`LSU_ADDR_LEN-1:0] addr;
		logic [`LSU_DATA_LEN-1:0] sdata;
		logic [`LSU_DATA_LEN-1:0] exp_res;
		logic [`LSU_DATA_LEN-1:0] ref_res;
		logic exp_err;
		logic ref_err;
		int cycles;
		clock = 1'b0;
		rstn = 1'b0;
		req_valid_i = 1'b0;
		alu_result_i = '0;
		store_data_i = '0;
		load_type_i = lsu_pkg::LOAD_NONE;
		store_type_i = lsu_pkg::STORE_NONE;
		for (int i = 0; i < `LSU_SRAM_WORDS; i++)
			ref_mem[WIDX_W'(i)] = '0;
		for (int i = 0; i < MAX_REQS * FIELDS; i++)
			trace_mem[TIDX_W'(i)] = EMPTY;
		$readmemh("verif/lsu_trace.txt", trace_mem);
		num_reqs = 0;
		while (num_reqs < MAX_REQS && trace_field(num_reqs, 0) !== EMPTY)
			num_reqs++;
		if (num_reqs == 0) begin
			$display("no requests found in verif/lsu_trace.txt");
			stop_run();
		end
		cycle_limit = num_reqs * 20 + 100;

		repeat (16) @(posedge clock);
		#1;
		rstn = 1'b1;
		@(negedge clock);
		if (ctrl_state != lsu_pkg::S_IDLE) begin
			$display("controller not idle after reset, found %s", ctrl_state.name());
			stop_run();
		end
		check_flag("done_o", done_o, 1'b0);
		check_flag("mem_inst_o", mem_inst_o, 1'b0);

		for (int n = 0; n < num_reqs; n++) begin
			req_index = n;
			kind = trace_field(n, 0);
			typ = trace_field(n, 1);
			addr = trace_field(n, 2);
			sdata = trace_field(n, 3);
			exp_res = trace_field(n, 4);
			err_field = trace_field(n, 5);
			exp_err = err_field[0];
			// stores and plain ALU requests write back the address
			ref_res = addr;
			ref_err = 1'b0;
			if (kind == KIND_LOAD) begin
				predict_load(addr, lsu_pkg::load_type_e'(typ[2:0]), ref_res, ref_err);
			end else if (kind == KIND_STORE) begin
				predict_store(addr, sdata, lsu_pkg::store_type_e'(typ[1:0]), ref_err);
			end else if (kind != KIND_ALU) begin
				$display("trace request %0d has an unknown kind %0h", n, kind);
				stop_run();
			end
			if (ref_res !== exp_res || ref_err !== exp_err) begin
				$display("trace request %0d disagrees with the reference memory model", n);
				stop_run();
			end
			issue_request(kind, typ, addr, sdata);
			wait_for_done(kind != KIND_ALU, cycles);
			check_data("wdata_o", wdata_o, exp_res);
			check_flag("err_o", err_o, exp_err);
			if (kind == KIND_ALU)
				check_cycles("done_o latency", cycles, 2);
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/lsu_pkg.sv
src/lsu_store_align.sv
src/lsu_load_extend.sv
src/lsu_ctrl.sv
src/axi_sram.sv
src/lsu_subsys_top.sv
verif/lsu_tb.sv

//--- Makefile
# Verilator build and run of the load/store subsystem testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
FLIST     ?= build.f
TOP       ?= lsu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
SIM_ARGS  ?=

SOURCES := $(filter %.sv %.v,$(shell cat $(FLIST)))
HEADERS := $(wildcard src/*.svh)
TRACE   := verif/lsu_trace.txt
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the simulator exits non-zero on $fatal, so make fails with it
run: $(SIM_BIN) $(TRACE)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/lsu_trace.txt
// kind type addr store_data expected_result expected_err, all hex, one request per line
// kind 0 alu 1 load 2 store; load type 1 lb 2 lh 3 lw 4 lbu 5 lhu; store type 1 sb 2 sh 3 sw

// non-memory requests pass the ALU result through
0 0 12345678 00000000 12345678 0
0 0 deadbeef 00000000 deadbeef 0

// word store then word load
2 3 80000010 cafef00d 80000010 0
1 3 80000010 00000000 cafef00d 0

// byte stores at each offset, upper data bits ignored
2 3 80000020 11223344 80000020 0
2 1 80000020 000000aa 80000020 0
2 1 80000021 ffffffbb 80000021 0
2 1 80000022 000000cc 80000022 0
2 1 80000023 123456dd 80000023 0
1 3 80000020 00000000 ddccbbaa 0

// halfword stores at offsets 0 and 2
2 2 80000030 ffffbeef 80000030 0
2 2 80000032 12348001 80000032 0
1 3 80000030 00000000 8001beef 0

// extension, word holds bytes 01 80 7f f0 from lane 0 up
2 3 80000040 f07f8001 80000040 0
1 1 80000040 00000000 00000001 0
1 1 80000041 00000000 ffffff80 0
1 1 80000042 00000000 0000007f 0
1 1 80000043 00000000 fffffff0 0
1 4 80000040 00000000 00000001 0
1 4 80000041 00000000 00000080 0
1 4 80000042 00000000 0000007f 0
1 4 80000043 00000000 000000f0 0
1 2 80000040 00000000 ffff8001 0
1 2 80000042 00000000 fffff07f 0
1 5 80000040 00000000 00008001 0
1 5 80000042 00000000 0000f07f 0

// outside the device region and the SRAM window
2 3 00001000 55555555 00001000 1
2 1 00001003 000000ee 00001003 1
1 3 00001000 00000000 00000000 1
1 1 00001003 00000000 00000000 1
2 3 800003fc 0badc0de 800003fc 0
2 1 80000400 000000ee 80000400 1
1 3 80000400 00000000 00000000 1
1 3 800003fc 00000000 0badc0de 0
1 3 80000000 00000000 00000000 0

// back-to-back mix
2 3 80000100 a5a5a5a5 80000100 0
1 4 80000101 00000000 000000a5 0
0 0 0000abcd 00000000 0000abcd 0
1 2 80000102 00000000 ffffa5a5 0
2 2 80000102 00001234 80000102 0
1 3 80000100 00000000 1234a5a5 0
